// ==== common/arena_pkg.sv ====
/*
  raster, board and palette constants for the 640x480 arena renderer
  colors are rrrgggbb words, board vectors are indexed row*GRID+col
*/
`default_nettype none

package arena_pkg;

	////////////////////////////////////////////////////////////////////////////
	// raster, 25 MHz pixel clock, 800x521 total
	////////////////////////////////////////////////////////////////////////////

	localparam int CNT_W          = 10;  // width of hc and vc
	localparam int H_TOTAL        = 800; // clocks per line
	localparam int V_TOTAL        = 521; // lines per frame
	localparam int H_SYNC         = 96;  // hsync low at start of line
	localparam int V_SYNC         = 2;   // vsync low at start of frame
	localparam int H_ACTIVE_START = 144; // first visible clock
	localparam int V_ACTIVE_START = 31;  // first visible line
	localparam int H_ACTIVE       = 640;
	localparam int V_ACTIVE       = 480;

	////////////////////////////////////////////////////////////////////////////
	// board geometry
	////////////////////////////////////////////////////////////////////////////

	localparam int GRID    = 10;           // tiles per row and per column
	localparam int TILE_W  = 64;           // pixels per tile
	localparam int TILE_H  = 48;           // lines per tile
	localparam int CELLS   = GRID * GRID;  // length of every board vector
	localparam int CELL_W  = $clog2(CELLS); // cell index width
	localparam int IDX_W   = 4;            // tile row / column width
	localparam int OFS_X_W = 6;
	localparam int OFS_Y_W = 6;

	// mortar lines of a brick tile, in-tile offsets
	localparam int MORTAR_N = 4;
	localparam logic [MORTAR_N-1:0][OFS_X_W-1:0] MORTAR_X = {
		6'd52, 6'd39, 6'd26, 6'd13
	};
	localparam logic [MORTAR_N-1:0][OFS_Y_W-1:0] MORTAR_Y = {
		6'd39, 6'd29, 6'd19, 6'd9
	};

	////////////////////////////////////////////////////////////////////////////
	// palette, rrr_ggg_bb
	////////////////////////////////////////////////////////////////////////////

	localparam logic [7:0] COL_BLACK      = 8'b000_000_00;
	localparam logic [7:0] COL_BACKGROUND = 8'b111_111_11; // empty tile
	localparam logic [7:0] COL_BOMB1      = 8'b101_001_11; // bomb stage 1
	localparam logic [7:0] COL_BOMB2      = 8'b100_000_11;
	localparam logic [7:0] COL_BOMB3      = 8'b111_000_00; // about to blow
	localparam logic [7:0] COL_PLAYER1    = 8'b000_111_00;
	localparam logic [7:0] COL_PLAYER2    = 8'b000_000_11;
	localparam logic [7:0] COL_BRICK      = 8'b110_010_00; // solid block face

endpackage

`default_nettype wire

// ==== source/vga_timing.sv ====
/*
  800x521 raster with negative syncs, all outputs registered one clock
  after the counters; active window is exclusive at its upper bounds
*/
`timescale 1ns/1ps
`default_nettype none

module vga_timing
	import arena_pkg::*;
(
	input  logic pixel_clk,
	input  logic rst,
	output logic hsync_o,       // low for H_SYNC clocks
	output logic vsync_o,       // low for V_SYNC lines
	output logic active_o,      // inside the 640x480 window
	output logic frame_start_o  // one clock at hc=0, vc=0
);

	logic [CNT_W-1:0] hc; // clock within line
	logic [CNT_W-1:0] vc; // line within frame
	logic h_last;
	logic v_last;
	logic h_vis;
	logic v_vis;

	assign h_last = (hc == CNT_W'(H_TOTAL - 1));
	assign v_last = (vc == CNT_W'(V_TOTAL - 1));

	// exclusive window, 144..783 and 31..510
	assign h_vis = (hc >= CNT_W'(H_ACTIVE_START)) &&
	               (hc < CNT_W'(H_ACTIVE_START + H_ACTIVE));
	assign v_vis = (vc >= CNT_W'(V_ACTIVE_START)) &&
	               (vc < CNT_W'(V_ACTIVE_START + V_ACTIVE));

	////////////////////////////////////////////////////////////////////////////
	// raster counters
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge pixel_clk or posedge rst)
	begin
		if (rst)
		begin
			hc <= '0;
			vc <= '0;
		end
		else if (h_last)
		begin
			hc <= '0; // end of line
			if (v_last)
				vc <= '0;
			else
				vc <= vc + 1'b1;
		end
		else
		begin
			hc <= hc + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// decoded outputs, one clock behind hc/vc
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge pixel_clk or posedge rst)
	begin
		if (rst)
		begin
			hsync_o       <= 1'b1; // idle high
			vsync_o       <= 1'b1;
			active_o      <= 1'b0;
			frame_start_o <= 1'b0;
		end
		else
		begin
			hsync_o       <= (hc >= CNT_W'(H_SYNC));
			vsync_o       <= (vc >= CNT_W'(V_SYNC));
			active_o      <= h_vis && v_vis;
			frame_start_o <= (hc == '0) && (vc == '0);
		end
	end

	// counter must never escape the line length
	a_hc_range: assert property (@(posedge pixel_clk) disable iff (rst)
		hc < CNT_W'(H_TOTAL));

endmodule

`default_nettype wire

// ==== render/tile_locator.sv ====
/*
  tracks tile column/row and in-tile offsets by counting, no divider
  relies on frame_start arriving before the first active line of a frame
*/
`timescale 1ns/1ps
`default_nettype none

module tile_locator
	import arena_pkg::*;
(
	input  logic               pixel_clk,
	input  logic               rst,
	input  logic               active_i,      // from vga_timing
	input  logic               frame_start_i, // restarts row tracking
	output logic [IDX_W-1:0]   tile_row_o,
	output logic [IDX_W-1:0]   tile_col_o,
	output logic [OFS_X_W-1:0] ofs_x_o,       // 0..63 within tile
	output logic [OFS_Y_W-1:0] ofs_y_o,       // 0..47 within tile
	output logic               tile_valid_o   // active, one clock later
);

	logic line_end; // falling edge of active
	logic x_wrap;
	logic y_wrap;

	assign line_end = tile_valid_o && !active_i;
	assign x_wrap   = (ofs_x_o == OFS_X_W'(TILE_W - 1));
	assign y_wrap   = (ofs_y_o == OFS_Y_W'(TILE_H - 1));

	always_ff @(posedge pixel_clk or posedge rst)
	begin
		if (rst)
			tile_valid_o <= 1'b0;
		else
			tile_valid_o <= active_i;
	end

	////////////////////////////////////////////////////////////////////////////
	// column state, held at zero through blanking
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge pixel_clk or posedge rst)
	begin
		if (rst)
		begin
			ofs_x_o    <= '0;
			tile_col_o <= '0;
		end
		else if (!active_i)
		begin
			ofs_x_o    <= '0;
			tile_col_o <= '0;
		end
		else if (tile_valid_o) // first pixel keeps the cleared zero
		begin
			if (x_wrap)
			begin
				ofs_x_o    <= '0;
				tile_col_o <= tile_col_o + 1'b1; // next tile to the right
			end
			else
			begin
				ofs_x_o <= ofs_x_o + 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// row state, steps once per visible line
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge pixel_clk or posedge rst)
	begin
		if (rst)
		begin
			ofs_y_o    <= '0;
			tile_row_o <= '0;
		end
		else if (frame_start_i)
		begin
			ofs_y_o    <= '0;
			tile_row_o <= '0;
		end
		else if (line_end)
		begin
			if (y_wrap)
			begin
				ofs_y_o    <= '0;
				tile_row_o <= tile_row_o + 1'b1; // reaches GRID after last line
			end
			else
			begin
				ofs_y_o <= ofs_y_o + 1'b1;
			end
		end
	end

	// counting must land on exactly GRID tiles each way
	a_col_range: assert property (@(posedge pixel_clk) disable iff (rst)
		tile_valid_o |-> (tile_col_o < IDX_W'(GRID)));
	a_row_range: assert property (@(posedge pixel_clk) disable iff (rst)
		tile_valid_o |-> (tile_row_o < IDX_W'(GRID)));

endmodule

`default_nettype wire

// ==== render/tile_painter.sv ====
/*
  picks one rrrgggbb color per pixel and registers it, syncs ride two
  stages to stay aligned; board inputs are read live, keep them frame-steady
*/
`timescale 1ns/1ps
`default_nettype none

module tile_painter
	import arena_pkg::*;
(
	input  logic               pixel_clk,
	input  logic               rst,
	input  logic               hsync_i,       // raw, from vga_timing
	input  logic               vsync_i,
	input  logic               tile_valid_i,
	input  logic [IDX_W-1:0]   tile_row_i,
	input  logic [IDX_W-1:0]   tile_col_i,
	input  logic [OFS_X_W-1:0] ofs_x_i,
	input  logic [OFS_Y_W-1:0] ofs_y_i,
	input  logic [CELLS-1:0]   arena_i,       // 1 = solid block
	input  logic [CELLS-1:0]   bomb_lo_i,
	input  logic [CELLS-1:0]   bomb_hi_i,
	input  logic [IDX_W-1:0]   player1_row_i,
	input  logic [IDX_W-1:0]   player1_col_i,
	input  logic [IDX_W-1:0]   player2_row_i,
	input  logic [IDX_W-1:0]   player2_col_i,
	input  logic [1:0]         game_over_i,   // nonzero blanks the screen
	output logic [2:0]         red_o,
	output logic [2:0]         green_o,
	output logic [1:0]         blue_o,
	output logic               hsync_o,
	output logic               vsync_o
);

	logic [CELL_W-1:0] cell_idx;  // row*GRID + col
	logic              is_p1;
	logic              is_p2;
	logic              on_mortar;
	logic [1:0]        bomb_code;
	logic [7:0]        pix_col;   // next color word
	logic              hsync_d1;
	logic              vsync_d1;

	assign cell_idx  = CELL_W'(tile_row_i) * CELL_W'(GRID) + CELL_W'(tile_col_i);
	assign is_p1     = (tile_row_i == player1_row_i) && (tile_col_i == player1_col_i);
	assign is_p2     = (tile_row_i == player2_row_i) && (tile_col_i == player2_col_i);
	assign bomb_code = {bomb_hi_i[cell_idx], bomb_lo_i[cell_idx]};

	// a mortar column or a mortar row anywhere in the tile
	always_comb
	begin
		on_mortar = 1'b0;
		for (int i = 0; i < MORTAR_N; i++)
		begin
			if ((ofs_x_i == MORTAR_X[i]) || (ofs_y_i == MORTAR_Y[i]))
				on_mortar = 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// color priority, first hit wins
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		if (!tile_valid_i || (game_over_i != 2'd0))
			pix_col = COL_BLACK;  // blanking or game over
		else if (is_p1)
			pix_col = COL_PLAYER1; // p1 beats p2 on a shared tile
		else if (is_p2)
			pix_col = COL_PLAYER2;
		else if (arena_i[cell_idx])
		begin
			if (on_mortar)
				pix_col = COL_BLACK;
			else
				pix_col = COL_BRICK;
		end
		else
		begin
			case (bomb_code)
				2'd1:    pix_col = COL_BOMB1;
				2'd2:    pix_col = COL_BOMB2;
				2'd3:    pix_col = COL_BOMB3;
				default: pix_col = COL_BACKGROUND; // empty floor
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// output stage
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge pixel_clk or posedge rst)
	begin
		if (rst)
		begin
			red_o   <= '0;
			green_o <= '0;
			blue_o  <= '0;
		end
		else
		begin
			red_o   <= pix_col[7:5];
			green_o <= pix_col[4:2];
			blue_o  <= pix_col[1:0];
		end
	end

	// two stages so the syncs match locator + color register
	always_ff @(posedge pixel_clk or posedge rst)
	begin
		if (rst)
		begin
			hsync_d1 <= 1'b1;
			vsync_d1 <= 1'b1;
			hsync_o  <= 1'b1;
			vsync_o  <= 1'b1;
		end
		else
		begin
			hsync_d1 <= hsync_i;
			vsync_d1 <= vsync_i;
			hsync_o  <= hsync_d1;
			vsync_o  <= vsync_d1;
		end
	end

	// visible lines never start inside the vertical sync pulse
	a_valid_vs_sync: assert property (@(posedge pixel_clk) disable iff (rst)
		$rose(tile_valid_i) |-> vsync_i);

endmodule

`default_nettype wire

// ==== source/vga_arena_top.sv ====
/*
  arena renderer top, three clocks from raster counters to the pins
  colors and syncs leave aligned, no back-pressure on the stream
*/
`timescale 1ns/1ps
`default_nettype none

module vga_arena_top
	import arena_pkg::*;
(
	input  logic             pixel_clk,
	input  logic             rst,
	input  logic [CELLS-1:0] arena_i,
	input  logic [CELLS-1:0] bomb_lo_i,
	input  logic [CELLS-1:0] bomb_hi_i,
	input  logic [IDX_W-1:0] player1_row_i,
	input  logic [IDX_W-1:0] player1_col_i,
	input  logic [IDX_W-1:0] player2_row_i,
	input  logic [IDX_W-1:0] player2_col_i,
	input  logic [1:0]       game_over_i,
	output logic             hsync_o,
	output logic             vsync_o,
	output logic [2:0]       red_o,
	output logic [2:0]       green_o,
	output logic [1:0]       blue_o
);

	// raster stage
	logic               hsync_raw;
	logic               vsync_raw;
	logic               active;
	logic               frame_start;

	// tile stage
	logic [IDX_W-1:0]   tile_row;
	logic [IDX_W-1:0]   tile_col;
	logic [OFS_X_W-1:0] ofs_x;
	logic [OFS_Y_W-1:0] ofs_y;
	logic               tile_valid;

	vga_timing u_timing (
		.pixel_clk     (pixel_clk),
		.rst           (rst),
		.hsync_o       (hsync_raw),
		.vsync_o       (vsync_raw),
		.active_o      (active),
		.frame_start_o (frame_start)
	);

	tile_locator u_locator (
		.pixel_clk     (pixel_clk),
		.rst           (rst),
		.active_i      (active),
		.frame_start_i (frame_start),
		.tile_row_o    (tile_row),
		.tile_col_o    (tile_col),
		.ofs_x_o       (ofs_x),
		.ofs_y_o       (ofs_y),
		.tile_valid_o  (tile_valid)
	);

	tile_painter u_painter (
		.pixel_clk     (pixel_clk),
		.rst           (rst),
		.hsync_i       (hsync_raw),
		.vsync_i       (vsync_raw),
		.tile_valid_i  (tile_valid),
		.tile_row_i    (tile_row),
		.tile_col_i    (tile_col),
		.ofs_x_i       (ofs_x),
		.ofs_y_i       (ofs_y),
		.arena_i       (arena_i),
		.bomb_lo_i     (bomb_lo_i),
		.bomb_hi_i     (bomb_hi_i),
		.player1_row_i (player1_row_i),
		.player1_col_i (player1_col_i),
		.player2_row_i (player2_row_i),
		.player2_col_i (player2_col_i),
		.game_over_i   (game_over_i),
		.red_o         (red_o),
		.green_o       (green_o),
		.blue_o        (blue_o),
		.hsync_o       (hsync_o),
		.vsync_o       (vsync_o)
	);

endmodule

`default_nettype wire

// ==== verification/tb_vga_arena.sv ====
/*
  directed tests for the arena renderer with pixels sampled on the falling edge
  expected colors come from the raster timing and the tile priority rules
*/
`timescale 1ns/1ps
`default_nettype none

module tb_vga_arena
	import arena_pkg::*;
();

	localparam int FRAME = H_TOTAL * V_TOTAL; // clocks per frame

	logic             pixel_clk;
	logic             rst;
	logic [CELLS-1:0] arena;
	logic [CELLS-1:0] bomb_lo;
	logic [CELLS-1:0] bomb_hi;
	logic [IDX_W-1:0] p1_row;
	logic [IDX_W-1:0] p1_col;
	logic [IDX_W-1:0] p2_row;
	logic [IDX_W-1:0] p2_col;
	logic [1:0]       game_over;
	logic             hsync;
	logic             vsync;
	logic [2:0]       red;
	logic [2:0]       green;
	logic [1:0]       blue;

	int          test_errors; // mismatches in the running test
	int          checks;
	int          tests_run;
	int          tests_bad;
	bit          timed_out;   // any wait gave up
	string       cur_test;
	int          cur_line;    // raster line since the last vsync fall
	logic [31:0] lfsr_state;
	int          ys[$];       // active lines to sample in increasing order
	int          xs[$];       // active columns to sample in increasing order

	vga_arena_top DUT (
		.pixel_clk     (pixel_clk),
		.rst           (rst),
		.arena_i       (arena),
		.bomb_lo_i     (bomb_lo),
		.bomb_hi_i     (bomb_hi),
		.player1_row_i (p1_row),
		.player1_col_i (p1_col),
		.player2_row_i (p2_row),
		.player2_col_i (p2_col),
		.game_over_i   (game_over),
		.hsync_o       (hsync),
		.vsync_o       (vsync),
		.red_o         (red),
		.green_o       (green),
		.blue_o        (blue)
	);

	always #2 pixel_clk = ~pixel_clk; // 4 ns pixel clock

	////////////////////////////////////////////////////////////////////////////
	// reference model and random board
	////////////////////////////////////////////////////////////////////////////

	// color of active pixel (x, y) where the first matching rule wins
	function automatic logic [7:0] expected_pixel(input int x, input int y);
		int         r;
		int         c;
		int         ox;
		int         oy;
		int         idx;
		logic [1:0] code;
		r    = y / 48;
		c    = x / 64;
		ox   = x % 64;
		oy   = y % 48;
		idx  = r * 10 + c;
		code = {bomb_hi[idx], bomb_lo[idx]};
		if (game_over != 2'd0)
			return COL_BLACK;
		if ((r == p1_row) && (c == p1_col))
			return COL_PLAYER1;
		if ((r == p2_row) && (c == p2_col))
			return COL_PLAYER2;
		if (arena[idx])
		begin
			if ((ox == 13) || (ox == 26) || (ox == 39) || (ox == 52) ||
			    (oy == 9) || (oy == 19) || (oy == 29) || (oy == 39))
				return COL_BLACK; // mortar line
			return COL_BRICK;
		end
		case (code)
			2'd1:    return COL_BOMB1;
			2'd2:    return COL_BOMB2;
			2'd3:    return COL_BOMB3;
			default: return COL_BACKGROUND;
		endcase
	endfunction

	// galois step shifting right with feedback on the bit shifted out
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h8020_0003;
		return s >> 1;
	endfunction

	task automatic random_vector(output logic [CELLS-1:0] v);
		for (int i = 0; i < CELLS; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state); // one step per bit
			v[i]       = lfsr_state[0];
		end
	endtask

	task automatic clear_board();
		arena     = '0;
		bomb_lo   = '0;
		bomb_hi   = '0;
		p1_row    = 4'd15; // off the board
		p1_col    = 4'd15;
		p2_row    = 4'd15;
		p2_col    = 4'd15;
		game_over = 2'd0;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// bounded waits
	////////////////////////////////////////////////////////////////////////////

	// returns on the falling edge where the chosen sync first shows level
	task automatic wait_sync_edge(input bit vert, input bit level, input int limit,
	                              output int cycles);
		logic prev;
		logic cur;
		cycles = 0;
		if (!timed_out)
		begin
			prev = vert ? vsync : hsync;
			cur  = prev;
			while (!((cur == level) && (prev != level)) && (cycles < limit))
			begin
				prev = cur;
				@(negedge pixel_clk);
				cur = vert ? vsync : hsync;
				cycles++;
			end
			if (!((cur == level) && (prev != level)))
			begin
				timed_out = 1'b1;
				$display("%s: no %s %s seen within %0d cycles", cur_test,
				         vert ? "vsync" : "hsync", level ? "rise" : "fall", limit);
			end
		end
	endtask

	task automatic find_frame();
		int n;
		wait_sync_edge(1'b1, 1'b0, 2 * FRAME, n); // hsync falls on the same clock
		cur_line = 0;
	endtask

	task automatic advance_to_line(input int line);
		int n;
		while ((cur_line < line) && !timed_out)
		begin
			wait_sync_edge(1'b0, 1'b0, 2 * H_TOTAL, n);
			cur_line++;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// checks and bookkeeping
	////////////////////////////////////////////////////////////////////////////

	task automatic check_color(input int x, input int y, input logic [7:0] exp);
		logic [7:0] got;
		got = {red, green, blue};
		checks++;
		assert (got === exp) else
		begin
			$display("Error %s pixel (%0d,%0d): expected %02h, actual %02h",
			         cur_test, x, y, exp, got);
			test_errors++;
		end
	endtask

	task automatic expect_int(input string what, input int exp, input int got);
		checks++;
		assert (got == exp) else
		begin
			$display("Error %s %s: expected %0d, actual %0d", cur_test, what, exp, got);
			test_errors++;
		end
	endtask

	task automatic begin_test(input string name);
		cur_test    = name;
		test_errors = 0;
		checks      = 0;
	endtask

	task automatic end_test();
		tests_run++;
		if ((test_errors != 0) || timed_out)
			tests_bad++;
		$display("%s: %0d checks, %0d mismatches", cur_test, checks, test_errors);
	endtask

	// samples every (ys, xs) pair of one frame
	// pixel x lands 144+x clocks after hsync falls
	task automatic scan_frame();
		int pos;
		int target;
		find_frame();
		for (int i = 0; i < ys.size(); i++)
		begin
			advance_to_line(V_ACTIVE_START + ys[i]);
			pos = 0;
			for (int j = 0; j < xs.size(); j++)
			begin
				target = H_ACTIVE_START + xs[j];
				repeat (target - pos) @(negedge pixel_clk);
				pos = target;
				if (!timed_out)
					check_color(xs[j], ys[i], expected_pixel(xs[j], ys[i]));
			end
		end
	endtask

	task automatic set_tile_centers();
		ys.delete();
		xs.delete();
		for (int k = 0; k < GRID; k++)
		begin
			ys.push_back(k * 48 + 24);
			xs.push_back(k * 64 + 32);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// directed tests
	////////////////////////////////////////////////////////////////////////////

	task automatic test_sync_timing();
		int n;
		int low;
		int high;
		begin_test("sync_timing");
		wait_sync_edge(1'b0, 1'b0, 2 * H_TOTAL, n);
		wait_sync_edge(1'b0, 1'b1, 2 * H_TOTAL, low);
		wait_sync_edge(1'b0, 1'b0, 2 * H_TOTAL, high);
		expect_int("hsync low", 96, low);
		expect_int("hsync period", 800, low + high);
		wait_sync_edge(1'b1, 1'b0, 2 * FRAME, n);
		wait_sync_edge(1'b1, 1'b1, 2 * FRAME, low);
		wait_sync_edge(1'b1, 1'b0, 2 * FRAME, high);
		expect_int("vsync low", 1600, low);
		expect_int("frame length", 416800, low + high);
		end_test();
	endtask

	// whole line with black porches and the window edges already lit
	task automatic test_blanking();
		int y;
		begin_test("blanking");
		clear_board();
		y = 200;
		find_frame();
		advance_to_line(V_ACTIVE_START + y);
		for (int pos = 0; pos < H_TOTAL; pos++)
		begin
			if (pos > 0)
				@(negedge pixel_clk);
			if (!timed_out)
			begin
				if ((pos >= 144) && (pos < 784))
					check_color(pos - 144, y, expected_pixel(pos - 144, y));
				else
					check_color(pos - 144, y, COL_BLACK);
			end
		end
		end_test();
	endtask

	task automatic test_random_bombs();
		begin_test("random_bombs");
		clear_board();
		random_vector(bomb_lo);
		random_vector(bomb_hi);
		set_tile_centers();
		scan_frame();
		end_test();
	endtask

	task automatic test_bricks();
		begin_test("bricks");
		clear_board();
		arena = '1;
		random_vector(bomb_lo); // bombs must stay hidden under bricks
		random_vector(bomb_hi);
		ys = '{0, 9, 20, 67, 125, 183, 239, 479}; // 9, 67, 125, 183 on mortar rows
		xs = '{0, 13, 20, 90, 167, 200, 628, 639}; // 13, 90, 167, 628 on mortar
		scan_frame();
		end_test();
	endtask

	task automatic test_players();
		begin_test("players");
		clear_board();
		random_vector(arena);
		random_vector(bomb_lo);
		random_vector(bomb_hi);
		p1_row = 4'd2;
		p1_col = 4'd3;
		p2_row = 4'd7;
		p2_col = 4'd8;
		set_tile_centers();
		scan_frame();
		// player 1 stays on top of a shared tile
		p1_row = 4'd5;
		p1_col = 4'd5;
		p2_row = 4'd5;
		p2_col = 4'd5;
		ys     = '{5 * 48 + 24};
		scan_frame();
		end_test();
	endtask

	task automatic test_game_over();
		begin_test("game_over");
		clear_board();
		random_vector(arena);
		random_vector(bomb_lo);
		random_vector(bomb_hi);
		p1_row    = 4'd0;
		p1_col    = 4'd0;
		p2_row    = 4'd9;
		p2_col    = 4'd9;
		set_tile_centers();
		for (int g = 1; g < 4; g++)
		begin
			game_over = g[1:0]; // every nonzero code blanks a full frame
			scan_frame();
		end
		game_over = 2'd0;
		end_test();
	endtask

	initial
	begin
		pixel_clk  = 1'b0;
		rst        = 1'b1;
		lfsr_state = 32'h1500;
		timed_out  = 1'b0;
		tests_run  = 0;
		tests_bad  = 0;
		cur_test   = "reset";
		clear_board();
		repeat (10) @(negedge pixel_clk);
		rst = 1'b0;

		test_sync_timing();
		test_blanking();
		test_random_bombs();
		test_bricks();
		test_players();
		test_game_over();

		$display("summary: %0d run, %0d clean, %0d with errors",
		         tests_run, tests_run - tests_bad, tests_bad);
		if ((tests_bad == 0) && !timed_out)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
common/arena_pkg.sv
source/vga_timing.sv
render/tile_locator.sv
render/tile_painter.sv
source/vga_arena_top.sv
verification/tb_vga_arena.sv
